//--- filelist.f
cdc_pkg.sv
cmd_parser.sv
pwm_bank.sv
uart_bridge.sv
dac_gen.sv
upload_mux.sv
cdc_top.sv
tb_cdc_top.sv

//--- Bender.yml
package:
  name: cdc_bench

sources:
  - cdc_pkg.sv
  - cmd_parser.sv
  - pwm_bank.sv
  - uart_bridge.sv
  - dac_gen.sv
  - upload_mux.sv
  - cdc_top.sv
  - target: simulation
    files:
      - tb_cdc_top.sv

//--- tb_cdc_top.sv
`timescale 1ns/1ps

module tb_cdc_top import cdc_pkg::*; ();

    // ========================================
    // run length
    // ========================================
    localparam int PWM_FRAMES      = 16;
    localparam int LEVEL_FRAMES    = 6;
    localparam int UART_FRAMES     = 8;
    localparam int GARBAGE_BYTES   = 24;
    localparam int RAMP_SAMPLES    = 32;
    localparam int TOTAL_FRAMES    = PWM_FRAMES + LEVEL_FRAMES + UART_FRAMES + 2
                                     + GARBAGE_BYTES / 4;
    localparam int FRAME_CYCLES    = 10 * CLKS_PER_BIT;
    localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * (FRAME_CYCLES + 12 * CLKS_PER_BIT)
                                     + 2000;
    // reply or loopback byte must show up within this
    localparam int UPLOAD_LIMIT    = 14 * CLKS_PER_BIT + 20;

    localparam logic [31:0] LFSR_SEED = 32'hb2f6c446;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic                    clk;
    logic                    rst_n_i;
    byte_t                   usb_data_i;
    logic                    usb_data_valid_i;
    byte_t                   usb_upload_data_o;
    logic                    usb_upload_valid_o;
    logic                    uart_line;
    logic [PWM_CHANNELS-1:0] pwm_pins_o;
    dac_code_t               dac_data_o;
    logic [1:0]              led_o;

    logic [31:0] lfsr_q = LFSR_SEED;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          tx_frames_seen = 0;
    byte_t       upload_q [$];
    byte_t       tx_expect_q [$];

    // model state
    duty_t       duty_model [PWM_CHANNELS];
    dac_code_t   dac_model;
    logic        led_model;

    // tx looped back onto rx
    cdc_top i_dut (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .usb_data_i         (usb_data_i),
        .usb_data_valid_i   (usb_data_valid_i),
        .usb_upload_data_o  (usb_upload_data_o),
        .usb_upload_valid_o (usb_upload_valid_o),
        .ext_uart_rx_i      (uart_line),
        .ext_uart_tx_o      (uart_line),
        .pwm_pins_o         (pwm_pins_o),
        .dac_data_o         (dac_data_o),
        .led_o              (led_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ========================================
    // helpers
    // ========================================
    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s expected 'h%0h, got 'h%0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic send_byte(input byte_t b);
        int gap;
        gap = rand_bits(2);
        repeat (gap) @(negedge clk);
        usb_data_i       = b;
        usb_data_valid_i = 1'b1;
        @(negedge clk);
        usb_data_valid_i = 1'b0;
    endtask

    task automatic send_frame(input byte_t cmd, input byte_t arg0, input byte_t arg1);
        send_byte(FRAME_SOF);
        send_byte(cmd);
        send_byte(arg0);
        send_byte(arg1);
    endtask

    task automatic get_upload(output byte_t b);
        int waited;
        waited = 0;
        while (upload_q.size() == 0 && waited < UPLOAD_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (upload_q.size() == 0) begin
            $display("error at %0t ns: no upload byte arrived within %0d cycles",
                     $time, UPLOAD_LIMIT);
            errors++;
            b = 'x;
        end else begin
            b = upload_q.pop_front();
        end
    endtask

    // frame led toggles once per acknowledged frame
    task automatic toggle_led_model();
        led_model = ~led_model;
        check("led_o[0]", led_model, led_o[0]);
    endtask

    // counts high cycles per pin over one period and compares with the duty model
    task automatic compare_pwm_model();
        int counts [PWM_CHANNELS];
        for (int ch = 0; ch < PWM_CHANNELS; ch++) begin
            counts[ch] = 0;
        end
        // let the last write pass a counter wrap
        repeat (512) @(negedge clk);
        repeat (256) begin
            @(negedge clk);
            for (int ch = 0; ch < PWM_CHANNELS; ch++) begin
                counts[ch] += pwm_pins_o[ch];
            end
        end
        for (int ch = 0; ch < PWM_CHANNELS; ch++) begin
            check($sformatf("pwm_pins_o[%0d] high cycles", ch), duty_model[ch], counts[ch]);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start) begin
            tests_passed++;
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail, %0d errors", name, errors - err_start);
        end
    endtask

    // ========================================
    // monitors
    // ========================================
    always @(negedge clk) begin
        if (usb_upload_valid_o === 1'b1) begin
            upload_q.push_back(usb_upload_data_o);
        end
    end

    // decodes the tx line at mid-bit
    initial begin : tx_decoder
        logic  prev_line;
        byte_t data;
        byte_t expected;
        prev_line = 1'b1;
        forever begin
            @(negedge clk);
            if (prev_line === 1'b1 && uart_line === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                check("ext_uart_tx_o start bit", 1'b0, uart_line);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    data[i] = uart_line;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                check("ext_uart_tx_o stop bit", 1'b1, uart_line);
                if (tx_expect_q.size() == 0) begin
                    $display("error at %0t ns: unexpected frame on the tx line", $time);
                    errors++;
                end else begin
                    expected = tx_expect_q.pop_front();
                    check("ext_uart_tx_o data", expected, data);
                end
                tx_frames_seen++;
            end
            prev_line = uart_line;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // ========================================
    // tests
    // ========================================
    task automatic reset_state_test();
        int err_start;
        err_start = errors;
        check("usb_upload_valid_o", 1'b0, usb_upload_valid_o);
        check("pwm_pins_o", '0, pwm_pins_o);
        check("dac_data_o", '0, dac_data_o);
        check("led_o", '0, led_o);
        check("ext_uart_tx_o", 1'b1, uart_line);
        report_test("reset state", err_start);
    endtask

    task automatic pwm_duty_test();
        int    err_start;
        byte_t arg0;
        byte_t duty;
        byte_t b;
        err_start = errors;
        for (int f = 0; f < PWM_FRAMES; f++) begin
            arg0 = rand_bits(8);
            duty = rand_bits(8);
            duty_model[arg0[2:0]] = duty;
            send_frame(CMD_PWM, arg0, duty);
            get_upload(b);
            check("usb_upload_data_o", CMD_PWM | ACK_FLAG, b);
            toggle_led_model();
        end
        compare_pwm_model();
        report_test("pwm duty", err_start);
    endtask

    task automatic dac_level_test();
        int    err_start;
        byte_t arg0;
        byte_t arg1;
        byte_t b;
        err_start = errors;
        for (int f = 0; f < LEVEL_FRAMES; f++) begin
            arg0 = rand_bits(8);
            arg1 = rand_bits(8);
            dac_model = {arg0[5:0], arg1};
            send_frame(CMD_DAC_LEVEL, arg0, arg1);
            get_upload(b);
            check("usb_upload_data_o", CMD_DAC_LEVEL | ACK_FLAG, b);
            check("dac_data_o", dac_model, dac_data_o);
            toggle_led_model();
        end
        report_test("dac level", err_start);
    endtask

    task automatic framing_test();
        int    err_start;
        byte_t junk;
        byte_t cmd;
        byte_t b;
        err_start = errors;
        for (int i = 0; i < GARBAGE_BYTES; i++) begin
            junk = rand_bits(8);
            if (junk == FRAME_SOF) begin
                junk = 8'h5A;
            end
            send_byte(junk);
        end
        repeat (20) @(negedge clk);
        check("upload bytes after garbage", 0, upload_q.size());
        // top bit set keeps it off the known codes
        cmd = {1'b1, 7'(rand_bits(7))};
        send_frame(cmd, rand_bits(8), rand_bits(8));
        get_upload(b);
        check("usb_upload_data_o", NAK_BYTE, b);
        check("led_o[0]", led_model, led_o[0]);
        check("dac_data_o", dac_model, dac_data_o);
        compare_pwm_model();
        report_test("framing and errors", err_start);
    endtask

    task automatic dac_ramp_test();
        int        err_start;
        byte_t     arg0;
        byte_t     arg1;
        byte_t     b;
        dac_code_t step;
        dac_code_t prev;
        dac_code_t diff;
        err_start = errors;
        arg0 = rand_bits(8);
        arg1 = rand_bits(8);
        step = {arg0[5:0], arg1};
        send_frame(CMD_DAC_RAMP, arg0, arg1);
        get_upload(b);
        check("usb_upload_data_o", CMD_DAC_RAMP | ACK_FLAG, b);
        toggle_led_model();
        prev = dac_data_o;
        for (int i = 0; i < RAMP_SAMPLES; i++) begin
            @(negedge clk);
            diff = dac_data_o - prev;
            check("dac_data_o step", step, diff);
            prev = dac_data_o;
        end
        report_test("dac ramp", err_start);
    endtask

    task automatic uart_loopback_test();
        int    err_start;
        int    seen_start;
        int    waited;
        byte_t data;
        byte_t b;
        err_start  = errors;
        seen_start = tx_frames_seen;
        for (int f = 0; f < UART_FRAMES; f++) begin
            data = rand_bits(8);
            tx_expect_q.push_back(data);
            send_frame(CMD_UART, data, rand_bits(8));
            get_upload(b);
            check("usb_upload_data_o reply", CMD_UART | ACK_FLAG, b);
            toggle_led_model();
            // transmitter still shifting the frame out
            check("led_o[1]", 1'b1, led_o[1]);
            get_upload(b);
            check("usb_upload_data_o loopback", data, b);
            check("led_o[1]", 1'b0, led_o[1]);
        end
        waited = 0;
        while (tx_frames_seen < seen_start + UART_FRAMES && waited < 4 * CLKS_PER_BIT) begin
            @(negedge clk);
            waited++;
        end
        check("tx frames decoded", seen_start + UART_FRAMES, tx_frames_seen);
        report_test("uart loopback", err_start);
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        rst_n_i          = 1'b0;
        usb_data_i       = '0;
        usb_data_valid_i = 1'b0;
        dac_model        = '0;
        led_model        = 1'b0;
        for (int ch = 0; ch < PWM_CHANNELS; ch++) begin
            duty_model[ch] = '0;
        end
        repeat (8) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);

        reset_state_test();
        pwm_duty_test();
        dac_level_test();
        framing_test();
        dac_ramp_test();
        uart_loopback_test();

        $display("summary: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- cdc_top.sv
`timescale 1ns/1ps

module cdc_top import cdc_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  byte_t                   usb_data_i,
    input  logic                    usb_data_valid_i,
    output byte_t                   usb_upload_data_o,
    output logic                    usb_upload_valid_o,
    input  logic                    ext_uart_rx_i,
    output logic                    ext_uart_tx_o,
    output logic [PWM_CHANNELS-1:0] pwm_pins_o,
    output dac_code_t               dac_data_o,
    output logic [1:0]              led_o
);

    // parser to register blocks
    logic      pwm_we;
    chan_t     pwm_chan;
    duty_t     pwm_duty;
    logic      dac_we;
    logic      dac_ramp;
    dac_code_t dac_value;

    // uart handshake and receive path
    logic      tx_req;
    logic      tx_ack;
    byte_t     tx_byte;
    byte_t     rx_byte;
    logic      rx_valid;

    byte_t     reply_byte;
    logic      reply_valid;

    // ========================================
    // command decode
    // ========================================
    cmd_parser i_cmd_parser (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .usb_data_i       (usb_data_i),
        .usb_data_valid_i (usb_data_valid_i),
        .tx_ack_i         (tx_ack),
        .pwm_we_o         (pwm_we),
        .pwm_chan_o       (pwm_chan),
        .pwm_duty_o       (pwm_duty),
        .dac_we_o         (dac_we),
        .dac_ramp_o       (dac_ramp),
        .dac_value_o      (dac_value),
        .tx_req_o         (tx_req),
        .tx_byte_o        (tx_byte),
        .reply_byte_o     (reply_byte),
        .reply_valid_o    (reply_valid),
        .frame_led_o      (led_o[0])
    );

    // ========================================
    // peripherals
    // ========================================
    pwm_bank i_pwm_bank (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .pwm_we_i   (pwm_we),
        .pwm_chan_i (pwm_chan),
        .pwm_duty_i (pwm_duty),
        .pwm_pins_o (pwm_pins_o)
    );

    uart_bridge i_uart_bridge (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .tx_req_i      (tx_req),
        .tx_byte_i     (tx_byte),
        .ext_uart_rx_i (ext_uart_rx_i),
        .tx_ack_o      (tx_ack),
        .tx_busy_o     (led_o[1]),
        .ext_uart_tx_o (ext_uart_tx_o),
        .rx_byte_o     (rx_byte),
        .rx_valid_o    (rx_valid)
    );

    dac_gen i_dac_gen (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .dac_we_i    (dac_we),
        .dac_ramp_i  (dac_ramp),
        .dac_value_i (dac_value),
        .dac_data_o  (dac_data_o)
    );

    // upload back to host
    upload_mux i_upload_mux (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .reply_byte_i       (reply_byte),
        .reply_valid_i      (reply_valid),
        .rx_byte_i          (rx_byte),
        .rx_valid_i         (rx_valid),
        .usb_upload_data_o  (usb_upload_data_o),
        .usb_upload_valid_o (usb_upload_valid_o)
    );

endmodule

//--- upload_mux.sv
`timescale 1ns/1ps

module upload_mux import cdc_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    input  byte_t reply_byte_i,
    input  logic  reply_valid_i,
    input  byte_t rx_byte_i,
    input  logic  rx_valid_i,
    output byte_t usb_upload_data_o,
    output logic  usb_upload_valid_o
);

    byte_t reply_q;
    logic  reply_full_q;
    byte_t rx_q;
    logic  rx_full_q;
    byte_t out_data_q;
    logic  out_valid_q;

    // holding slots
    always_ff @(posedge clk) begin
        if (reply_valid_i) begin
            reply_q <= reply_byte_i;
        end
        if (rx_valid_i) begin
            rx_q <= rx_byte_i;
        end
    end

    // ========================================
    // arbitration, reply first
    // ========================================
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reply_full_q <= 1'b0;
            rx_full_q    <= 1'b0;
            out_valid_q  <= 1'b0;
            out_data_q   <= '0;
        end else begin
            out_valid_q <= reply_full_q || rx_full_q;
            if (reply_full_q) begin
                out_data_q   <= reply_q;
                reply_full_q <= 1'b0;
            end else if (rx_full_q) begin
                out_data_q <= rx_q;
                rx_full_q  <= 1'b0;
            end
            // a new arrival refills the slot just drained
            if (reply_valid_i) begin
                reply_full_q <= 1'b1;
            end
            if (rx_valid_i) begin
                rx_full_q <= 1'b1;
            end
        end
    end

    assign usb_upload_data_o  = out_data_q;
    assign usb_upload_valid_o = out_valid_q;

endmodule

//--- dac_gen.sv
`timescale 1ns/1ps

module dac_gen import cdc_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      dac_we_i,
    input  logic      dac_ramp_i,
    input  dac_code_t dac_value_i,
    output dac_code_t dac_data_o
);

    logic      ramp_q;
    dac_code_t step_q;
    dac_code_t data_q;

    // ========================================
    // level / ramp register
    // ========================================
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ramp_q <= 1'b0;
            step_q <= '0;
            data_q <= '0;
        end else if (dac_we_i) begin
            ramp_q <= dac_ramp_i;
            if (dac_ramp_i) begin
                // first step lands right away, from the current level
                step_q <= dac_value_i;
                data_q <= data_q + dac_value_i;
            end else begin
                data_q <= dac_value_i;
            end
        end else if (ramp_q) begin
            // wraps mod 2^14
            data_q <= data_q + step_q;
        end
    end

    assign dac_data_o = data_q;

endmodule

//--- uart_bridge.sv
`timescale 1ns/1ps

module uart_bridge import cdc_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  tx_req_i,
    input  byte_t tx_byte_i,
    input  logic  ext_uart_rx_i,
    output logic  tx_ack_o,
    output logic  tx_busy_o,
    output logic  ext_uart_tx_o,
    output byte_t rx_byte_o,
    output logic  rx_valid_o
);

    // ========================================
    // transmitter
    // ========================================
    logic                       tx_ack_q;
    logic                       tx_busy_q;
    logic                       tx_line_q;
    logic [UART_FRAME_BITS-1:0] tx_shift_q;
    logic [UART_CNT_W-1:0]      tx_clk_q;
    logic [3:0]                 tx_bit_q;
    logic                       tx_accept;
    logic                       tx_tick;

    assign tx_accept = tx_req_i && !tx_ack_q;
    assign tx_tick   = tx_busy_q && (tx_clk_q == '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_ack_q  <= 1'b0;
            tx_busy_q <= 1'b0;
            tx_line_q <= 1'b1;
            tx_clk_q  <= '0;
            tx_bit_q  <= '0;
        end else begin
            if (tx_accept) begin
                tx_ack_q  <= 1'b1;
                tx_busy_q <= 1'b1;
                tx_clk_q  <= '0;
                tx_bit_q  <= '0;
            end else if (tx_ack_q && !tx_busy_q && !tx_req_i) begin
                // ack held until the stop bit is out
                tx_ack_q <= 1'b0;
            end

            if (tx_busy_q) begin
                if (tx_clk_q == UART_CNT_W'(CLKS_PER_BIT - 1)) begin
                    tx_clk_q <= '0;
                end else begin
                    tx_clk_q <= tx_clk_q + 1'b1;
                end
                if (tx_tick) begin
                    if (tx_bit_q == 4'(UART_FRAME_BITS)) begin
                        tx_busy_q <= 1'b0;
                    end else begin
                        tx_line_q <= tx_shift_q[0];
                        tx_bit_q  <= tx_bit_q + 4'd1;
                    end
                end
            end
        end
    end

    // stop, data lsb first, start
    always_ff @(posedge clk) begin
        if (tx_accept) begin
            tx_shift_q <= {1'b1, tx_byte_i, 1'b0};
        end else if (tx_tick) begin
            tx_shift_q <= {1'b1, tx_shift_q[UART_FRAME_BITS-1:1]};
        end
    end

    assign tx_ack_o      = tx_ack_q;
    assign tx_busy_o     = tx_busy_q;
    assign ext_uart_tx_o = tx_line_q;

    // ========================================
    // receiver
    // ========================================
    logic [1:0]            rx_sync_q;
    logic                  rx_prev_q;
    logic                  rx_s;
    logic                  rx_active_q;
    logic [UART_CNT_W-1:0] rx_clk_q;
    logic [3:0]            rx_bit_q;
    byte_t                 rx_shift_q;
    logic                  rx_valid_q;
    logic                  rx_sample;

    assign rx_s      = rx_sync_q[1];
    assign rx_sample = rx_active_q && (rx_clk_q == UART_CNT_W'(UART_MID));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_sync_q   <= '1;
            rx_prev_q   <= 1'b1;
            rx_active_q <= 1'b0;
            rx_clk_q    <= '0;
            rx_bit_q    <= '0;
            rx_valid_q  <= 1'b0;
        end else begin
            rx_sync_q  <= {rx_sync_q[0], ext_uart_rx_i};
            rx_prev_q  <= rx_s;
            rx_valid_q <= 1'b0;
            if (!rx_active_q) begin
                // falling edge = start bit
                if (rx_prev_q && !rx_s) begin
                    rx_active_q <= 1'b1;
                    rx_clk_q    <= '0;
                    rx_bit_q    <= '0;
                end
            end else begin
                if (rx_clk_q == UART_CNT_W'(CLKS_PER_BIT - 1)) begin
                    rx_clk_q <= '0;
                end else begin
                    rx_clk_q <= rx_clk_q + 1'b1;
                end
                if (rx_sample) begin
                    rx_bit_q <= rx_bit_q + 4'd1;
                    if (rx_bit_q == '0 && rx_s) begin
                        // start glitch, back to idle
                        rx_active_q <= 1'b0;
                    end else if (rx_bit_q == 4'(UART_FRAME_BITS - 1)) begin
                        rx_active_q <= 1'b0;
                        rx_valid_q  <= rx_s;
                    end
                end
            end
        end
    end

    // data bits only
    always_ff @(posedge clk) begin
        if (rx_sample && rx_bit_q != '0 && rx_bit_q != 4'(UART_FRAME_BITS - 1)) begin
            rx_shift_q <= {rx_s, rx_shift_q[7:1]};
        end
    end

    assign rx_byte_o  = rx_shift_q;
    assign rx_valid_o = rx_valid_q;

endmodule

//--- pwm_bank.sv
`timescale 1ns/1ps

module pwm_bank import cdc_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    pwm_we_i,
    input  chan_t                   pwm_chan_i,
    input  duty_t                   pwm_duty_i,
    output logic [PWM_CHANNELS-1:0] pwm_pins_o
);

    duty_t                   duty_q   [PWM_CHANNELS];
    duty_t                   active_q [PWM_CHANNELS];
    duty_t                   cnt_q;
    logic                    wrap;
    logic [PWM_CHANNELS-1:0] pins_q;

    assign wrap = (cnt_q == '1);

    // shared period counter
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 8'd1;
        end
    end

    // new duty only goes live at wrap, so no glitched period
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < PWM_CHANNELS; i++) begin
                duty_q[i]   <= '0;
                active_q[i] <= '0;
            end
        end else begin
            if (pwm_we_i) begin
                duty_q[pwm_chan_i] <= pwm_duty_i;
            end
            if (wrap) begin
                active_q <= duty_q;
            end
        end
    end

    // compare stage
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pins_q <= '0;
        end else begin
            for (int i = 0; i < PWM_CHANNELS; i++) begin
                pins_q[i] <= (cnt_q < active_q[i]);
            end
        end
    end

    assign pwm_pins_o = pins_q;

endmodule

//--- cmd_parser.sv
`timescale 1ns/1ps

module cmd_parser import cdc_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  byte_t     usb_data_i,
    input  logic      usb_data_valid_i,
    input  logic      tx_ack_i,
    output logic      pwm_we_o,
    output chan_t     pwm_chan_o,
    output duty_t     pwm_duty_o,
    output logic      dac_we_o,
    output logic      dac_ramp_o,
    output dac_code_t dac_value_o,
    output logic      tx_req_o,
    output byte_t     tx_byte_o,
    output byte_t     reply_byte_o,
    output logic      reply_valid_o,
    output logic      frame_led_o
);

    parser_state_t state_q;
    byte_t         cmd_q;
    byte_t         arg0_q;
    byte_t         arg1_q;
    logic          tx_req_q;
    logic          frame_led_q;

    logic in_exec;
    logic is_uart;
    logic cmd_known;
    logic uart_done;
    logic exec_done;

    assign in_exec   = (state_q == execute);
    assign is_uart   = (cmd_q == CMD_UART);
    assign cmd_known = cmd_q inside {CMD_PWM, CMD_UART, CMD_DAC_LEVEL, CMD_DAC_RAMP};
    assign uart_done = tx_req_q && tx_ack_i;
    // uart frames hold execute until the bridge has taken the byte
    assign exec_done = in_exec && (!is_uart || uart_done);

    // ========================================
    // frame FSM
    // ========================================
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= idle;
            cmd_q       <= '0;
            tx_req_q    <= 1'b0;
            frame_led_q <= 1'b0;
        end else begin
            case (state_q)
                idle: begin
                    // hunt for start of frame
                    if (usb_data_valid_i && usb_data_i == FRAME_SOF) begin
                        state_q <= get_cmd;
                    end
                end
                get_cmd: begin
                    if (usb_data_valid_i) begin
                        cmd_q   <= usb_data_i;
                        state_q <= get_arg0;
                    end
                end
                get_arg0: begin
                    if (usb_data_valid_i) begin
                        state_q <= get_arg1;
                    end
                end
                get_arg1: begin
                    if (usb_data_valid_i) begin
                        state_q <= execute;
                    end
                end
                execute: begin
                    // host bytes are dropped here
                    if (exec_done) begin
                        state_q <= idle;
                    end
                end
                default: state_q <= idle;
            endcase

            // four-phase req, wait for the previous ack to clear first
            if (in_exec && is_uart) begin
                if (uart_done) begin
                    tx_req_q <= 1'b0;
                end else if (!tx_ack_i) begin
                    tx_req_q <= 1'b1;
                end
            end

            if (exec_done && cmd_known) begin
                frame_led_q <= ~frame_led_q;
            end
        end
    end

    // argument bytes
    always_ff @(posedge clk) begin
        if (usb_data_valid_i && state_q == get_arg0) begin
            arg0_q <= usb_data_i;
        end
        if (usb_data_valid_i && state_q == get_arg1) begin
            arg1_q <= usb_data_i;
        end
    end

    // ========================================
    // dispatch
    // ========================================
    assign pwm_we_o    = in_exec && (cmd_q == CMD_PWM);
    assign pwm_chan_o  = arg0_q[2:0];
    assign pwm_duty_o  = arg1_q;

    assign dac_we_o    = in_exec && (cmd_q == CMD_DAC_LEVEL || cmd_q == CMD_DAC_RAMP);
    assign dac_ramp_o  = (cmd_q == CMD_DAC_RAMP);
    // level code or ramp step, same packing
    assign dac_value_o = {arg0_q[5:0], arg1_q};

    assign tx_req_o    = tx_req_q;
    assign tx_byte_o   = arg0_q;

    assign reply_valid_o = exec_done;
    assign reply_byte_o  = cmd_known ? (cmd_q | ACK_FLAG) : NAK_BYTE;
    assign frame_led_o   = frame_led_q;

endmodule

//--- cdc_pkg.sv
package cdc_pkg;

    // ========================================
    // widths
    // ========================================
    localparam int PWM_CHANNELS = 8;
    localparam int DAC_W        = 14;

    typedef logic [7:0]       byte_t;
    typedef logic [7:0]       duty_t;
    typedef logic [DAC_W-1:0] dac_code_t;
    typedef logic [2:0]       chan_t;

    // ========================================
    // host frame format
    // ========================================
    // every frame is SOF, cmd, arg0, arg1
    localparam byte_t FRAME_SOF     = 8'hA5;

    localparam byte_t CMD_PWM       = 8'h01;
    localparam byte_t CMD_UART      = 8'h02;
    localparam byte_t CMD_DAC_LEVEL = 8'h03;
    localparam byte_t CMD_DAC_RAMP  = 8'h04;

    localparam byte_t ACK_FLAG      = 8'h80;
    localparam byte_t NAK_BYTE      = 8'hEE;

    // ========================================
    // uart timing
    // ========================================
    localparam int CLKS_PER_BIT    = 8;
    localparam int UART_CNT_W      = $clog2(CLKS_PER_BIT);
    // sample point, counted from one cycle after the start edge is seen
    localparam int UART_MID        = CLKS_PER_BIT / 2 - 1;
    // start, eight data bits, stop
    localparam int UART_FRAME_BITS = 10;

    typedef enum logic [2:0] {
        idle,
        get_cmd,
        get_arg0,
        get_arg1,
        execute
    } parser_state_t;

endpackage
